// ==== rtl/cache_pkg.sv ====
// Instruction cache geometry.
// Address field widths and the types built from them.

package cache_pkg;

    // --------------------
    // Geometry.
    // --------------------
    localparam int BLOCK_COUNT = 4;
    localparam int WORD_SIZE   = 32;
    localparam int BLOCK_WIDTH = 512;
    localparam int ADDR_WIDTH  = 64;

    // Derived field widths.
    localparam int WORD_COUNT    = BLOCK_WIDTH / WORD_SIZE;
    localparam int WORD_OFFSET_W = $clog2(WORD_COUNT);
    localparam int INDEX_W       = $clog2(BLOCK_COUNT);
    localparam int BYTE_OFFSET_W = $clog2(WORD_SIZE / 8);
    localparam int TAG_W         = ADDR_WIDTH - INDEX_W - WORD_OFFSET_W - BYTE_OFFSET_W;

    // --------------------
    // Types.
    // --------------------
    typedef logic [ADDR_WIDTH-1:0]    addr_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [WORD_OFFSET_W-1:0] word_off_t;
    typedef logic [BLOCK_WIDTH-1:0]   line_t;
    typedef logic [WORD_SIZE-1:0]     instr_t;

endpackage

// ==== rtl/fetch_pkg.sv ====
// Memory beat format for line refills.
// State encoding of the fetch controller FSM.

package fetch_pkg;

    // --------------------
    // Memory beats.
    // --------------------
    localparam int BEAT_WIDTH     = 64;
    // One line is filled by this many beats.
    localparam int BEATS_PER_LINE = cache_pkg::BLOCK_WIDTH / BEAT_WIDTH;

    typedef logic [BEAT_WIDTH-1:0]             beat_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;

    // --------------------
    // Controller states.
    // --------------------
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL,
        WRITE
    } fetch_state_t;

endpackage

// ==== rtl/cache_lookup_if.sv ====
// Lookup bundle between the fetch controller, the cache and the result stage.

`timescale 1ns/1ps

interface cache_lookup_if;
    import cache_pkg::*;

    // Address under lookup, held by the controller.
    addr_t  addr;

    // Combinational answer of the cache.
    instr_t instr;
    logic   hit;
    logic   addr_ma;

    modport cache (
        input  addr,
        output instr,
        output hit,
        output addr_ma
    );

    modport ctrl (
        output addr,
        input  hit,
        input  addr_ma
    );

    modport result (
        input  instr,
        input  addr_ma
    );

endinterface

// ==== rtl/instr_cache.sv ====
// Direct-mapped instruction cache.
// Tag, valid and line arrays, hit detection and word select.

`timescale 1ns/1ps

module instr_cache (
    input  logic                 clk,
    input  logic                 arst,
    input  logic                 i_write_en,
    input  cache_pkg::line_t     i_line,
    input  logic                 i_invalidate,
    cache_lookup_if.cache        lookup
);
    import cache_pkg::*;

    // --------------------
    // Address fields.
    // --------------------
    tag_t      s_tag_in;
    index_t    s_index;
    word_off_t s_word_offset;

    assign s_tag_in      = lookup.addr[ADDR_WIDTH-1 -: TAG_W];
    assign s_index       = lookup.addr[BYTE_OFFSET_W + WORD_OFFSET_W +: INDEX_W];
    assign s_word_offset = lookup.addr[BYTE_OFFSET_W +: WORD_OFFSET_W];

    // --------------------
    // Storage.
    // --------------------
    tag_t                   tag_mem  [BLOCK_COUNT];
    line_t                  line_mem [BLOCK_COUNT];
    logic [BLOCK_COUNT-1:0] valid_mem;

    // Valid bits. Flush wins over a fill in the same cycle.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            valid_mem <= '0;
        end
        else if (i_invalidate) begin
            valid_mem <= '0;
        end
        else if (i_write_en) begin
            valid_mem[s_index] <= 1'b1;
        end
    end

    // Tag and line arrays.
    always_ff @(posedge clk) begin
        if (i_write_en) begin
            tag_mem[s_index]  <= s_tag_in;
            line_mem[s_index] <= i_line;
        end
    end

    // --------------------
    // Lookup answer.
    // --------------------
    tag_t  s_tag;
    line_t s_line;
    logic  s_valid;

    assign s_tag   = tag_mem[s_index];
    assign s_line  = line_mem[s_index];
    assign s_valid = valid_mem[s_index];

    assign lookup.hit   = s_valid & (s_tag == s_tag_in);
    assign lookup.instr = s_line[s_word_offset * WORD_SIZE +: WORD_SIZE];

    // Any set byte offset bit is a misaligned fetch.
    assign lookup.addr_ma = |lookup.addr[BYTE_OFFSET_W-1:0];

endmodule

// ==== rtl/line_assembler.sv ====
// Refill line assembler.
// Places each memory beat into the line by its beat count.

`timescale 1ns/1ps

module line_assembler (
    input  logic              clk,
    input  logic              arst,
    input  logic              i_start,
    input  logic              i_beat_valid,
    input  fetch_pkg::beat_t  i_beat,
    output cache_pkg::line_t  o_line,
    output logic              o_done
);
    import fetch_pkg::*;

    beat_cnt_t s_cnt;
    logic      s_last;

    // Beat counter, restarted for every refill.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            s_cnt <= '0;
        end
        else if (i_start) begin
            s_cnt <= '0;
        end
        else if (i_beat_valid) begin
            s_cnt <= s_cnt + 1'b1;
        end
    end

    // Beat k lands in bits [64k+63:64k].
    always_ff @(posedge clk) begin
        if (i_beat_valid) begin
            o_line[s_cnt * BEAT_WIDTH +: BEAT_WIDTH] <= i_beat;
        end
    end

    assign s_last = (s_cnt == beat_cnt_t'(BEATS_PER_LINE - 1));

    // High in the cycle of the eighth beat.
    assign o_done = i_beat_valid & s_last;

endmodule

// ==== rtl/fetch_ctrl.sv ====
// Fetch controller FSM.
// Request capture, hit/miss/misaligned decision, refill sequencing.

`timescale 1ns/1ps

module fetch_ctrl (
    input  logic              clk,
    input  logic              arst,
    input  logic              i_fetch_req,
    input  cache_pkg::addr_t  i_fetch_addr,
    input  logic              i_flush,
    cache_lookup_if.ctrl      lookup,
    input  logic              i_line_done,
    output logic              o_asm_start,
    output logic              o_write_en,
    output logic              o_invalidate,
    output logic              o_mem_req,
    output cache_pkg::addr_t  o_mem_addr,
    output logic              o_deliver,
    output logic              o_busy
);
    import cache_pkg::*;
    import fetch_pkg::*;

    fetch_state_t s_state;
    fetch_state_t s_state_next;
    addr_t        s_addr;
    logic         s_accept;
    logic         s_answer;
    logic         s_miss;
    logic         s_deliver_q;

    // --------------------
    // Decode.
    // --------------------
    assign s_accept = i_fetch_req & ~o_busy;
    assign s_answer = (s_state == LOOKUP) & (lookup.addr_ma | lookup.hit);
    assign s_miss   = (s_state == LOOKUP) & ~lookup.addr_ma & ~lookup.hit;

    always_comb begin
        s_state_next = s_state;
        case (s_state)
            IDLE:    if (s_accept) s_state_next = LOOKUP;
            LOOKUP:  s_state_next = s_answer ? IDLE : REFILL;
            REFILL:  if (i_line_done) s_state_next = WRITE;
            WRITE:   s_state_next = LOOKUP;
            default: s_state_next = IDLE;
        endcase
    end

    // --------------------
    // State and strobes.
    // --------------------
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            s_state     <= IDLE;
            s_deliver_q <= 1'b0;
            o_mem_req   <= 1'b0;
        end
        else begin
            s_state     <= s_state_next;
            s_deliver_q <= s_answer;
            // Held from the miss until the last beat is taken.
            if (s_miss) begin
                o_mem_req <= 1'b1;
            end
            else if ((s_state == REFILL) & i_line_done) begin
                o_mem_req <= 1'b0;
            end
        end
    end

    // Request address, stable for the whole fetch.
    always_ff @(posedge clk) begin
        if (s_accept) begin
            s_addr <= i_fetch_addr;
        end
    end

    assign lookup.addr = s_addr;

    // Line-aligned refill address.
    assign o_mem_addr = {s_addr[ADDR_WIDTH-1:BYTE_OFFSET_W + WORD_OFFSET_W],
                         {(BYTE_OFFSET_W + WORD_OFFSET_W){1'b0}}};

    assign o_asm_start  = s_miss;
    assign o_write_en   = (s_state == WRITE);
    assign o_deliver    = s_deliver_q;
    // Busy until the result stage shows the answer.
    assign o_busy       = (s_state != IDLE) | s_deliver_q;
    assign o_invalidate = i_flush & ~o_busy;

endmodule

// ==== rtl/fetch_result.sv ====
// Fetch result register.
// Instruction word, misaligned flag and the valid pulse.

`timescale 1ns/1ps

module fetch_result (
    input  logic               clk,
    input  logic               arst,
    input  logic               i_deliver,
    cache_lookup_if.result     lookup,
    output cache_pkg::instr_t  o_instr,
    output logic               o_instr_addr_ma,
    output logic               o_instr_valid
);

    // One-cycle valid pulse per delivery.
    always_ff @(posedge clk, posedge arst) begin
        if (arst) begin
            o_instr_valid <= 1'b0;
        end
        else begin
            o_instr_valid <= i_deliver;
        end
    end

    // A misaligned fetch returns a zero word.
    always_ff @(posedge clk) begin
        if (i_deliver) begin
            o_instr         <= lookup.addr_ma ? '0 : lookup.instr;
            o_instr_addr_ma <= lookup.addr_ma;
        end
    end

endmodule

// ==== rtl/instr_fetch_top.sv ====
// Instruction fetch front end.
// Controller, direct-mapped cache, refill assembler and result register.

`timescale 1ns/1ps

module instr_fetch_top (
    input  logic        clk,
    input  logic        arst,

    // Fetch side.
    input  logic        i_fetch_req,
    input  logic [63:0] i_fetch_addr,
    input  logic        i_flush,
    output logic [31:0] o_instr,
    output logic        o_instr_valid,
    output logic        o_instr_addr_ma,
    output logic        o_busy,

    // Memory side.
    output logic        o_mem_req,
    output logic [63:0] o_mem_addr,
    input  logic        i_mem_beat_valid,
    input  logic [63:0] i_mem_beat
);

    cache_lookup_if   lookup ();

    cache_pkg::line_t s_line;
    logic             s_line_done;
    logic             s_asm_start;
    logic             s_write_en;
    logic             s_invalidate;
    logic             s_deliver;

    // --------------------
    // Decode.
    // --------------------
    fetch_ctrl u_ctrl (
        .clk          (clk),
        .arst         (arst),
        .i_fetch_req  (i_fetch_req),
        .i_fetch_addr (i_fetch_addr),
        .i_flush      (i_flush),
        .lookup       (lookup.ctrl),
        .i_line_done  (s_line_done),
        .o_asm_start  (s_asm_start),
        .o_write_en   (s_write_en),
        .o_invalidate (s_invalidate),
        .o_mem_req    (o_mem_req),
        .o_mem_addr   (o_mem_addr),
        .o_deliver    (s_deliver),
        .o_busy       (o_busy)
    );

    // --------------------
    // Execute.
    // --------------------
    instr_cache u_cache (
        .clk          (clk),
        .arst         (arst),
        .i_write_en   (s_write_en),
        .i_line       (s_line),
        .i_invalidate (s_invalidate),
        .lookup       (lookup.cache)
    );

    line_assembler u_asm (
        .clk          (clk),
        .arst         (arst),
        .i_start      (s_asm_start),
        .i_beat_valid (i_mem_beat_valid),
        .i_beat       (i_mem_beat),
        .o_line       (s_line),
        .o_done       (s_line_done)
    );

    // --------------------
    // Result.
    // --------------------
    fetch_result u_result (
        .clk             (clk),
        .arst            (arst),
        .i_deliver       (s_deliver),
        .lookup          (lookup.result),
        .o_instr         (o_instr),
        .o_instr_addr_ma (o_instr_addr_ma),
        .o_instr_valid   (o_instr_valid)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
// Memory responder for line refills.
// Returns eight beats per request with random gaps.

`timescale 1ns/1ps

module tb_mem_model #(
    parameter logic [31:0] SALT = 32'h0
) (
    input  logic        clk,
    input  logic        i_mem_req,
    input  logic [63:0] i_mem_addr,
    output logic        o_beat_valid,
    output logic [63:0] o_beat
);
    int beat_idx;
    int gap;

    // Word held at an aligned byte address.
    function automatic logic [31:0] mem_word(input logic [63:0] addr);
        return addr[31:0] ^ SALT;
    endfunction

    initial begin
        o_beat_valid = 1'b0;
        o_beat       = '0;
        beat_idx     = 0;
        gap          = 0;
    end

    // Beats change on the falling edge only.
    always @(negedge clk) begin
        o_beat_valid = 1'b0;
        if (!i_mem_req) begin
            beat_idx = 0;
            gap      = $urandom_range(3, 0);
        end
        else if (beat_idx < 8) begin
            if (gap == 0) begin
                // Even word in the low half, odd word in the high half.
                o_beat_valid = 1'b1;
                o_beat = {mem_word(i_mem_addr + 64'(8 * beat_idx + 4)),
                          mem_word(i_mem_addr + 64'(8 * beat_idx))};
                beat_idx++;
                gap = $urandom_range(3, 0);
            end
            else begin
                gap--;
            end
        end
    end

endmodule

// ==== sim/tb_instr_fetch_top.sv ====
// Testbench for the instruction fetch front end.
// Clock, reset, fetch stimulus, assertions and the test report.

`timescale 1ns/1ps

module tb_instr_fetch_top;
    import cache_pkg::*;

    localparam logic [31:0] SALT  = 32'h5a3c_96e1;
    localparam int          LIMIT = 200;

    logic        clk;
    logic        arst;
    logic        i_fetch_req;
    addr_t       i_fetch_addr;
    logic        i_flush;
    instr_t      o_instr;
    logic        o_instr_valid;
    logic        o_instr_addr_ma;
    logic        o_busy;
    logic        o_mem_req;
    addr_t       o_mem_addr;
    logic        mem_beat_valid;
    logic [63:0] mem_beat;

    int    errors;
    int    tests;
    int    failed_tests;
    int    req_count;
    int    valid_count;
    addr_t req_addr;
    logic  req_seen;
    bit    aborted;
    addr_t base;
    addr_t spread [4];

    instr_fetch_top i_dut (
        .clk              (clk),
        .arst             (arst),
        .i_fetch_req      (i_fetch_req),
        .i_fetch_addr     (i_fetch_addr),
        .i_flush          (i_flush),
        .o_instr          (o_instr),
        .o_instr_valid    (o_instr_valid),
        .o_instr_addr_ma  (o_instr_addr_ma),
        .o_busy           (o_busy),
        .o_mem_req        (o_mem_req),
        .o_mem_addr       (o_mem_addr),
        .i_mem_beat_valid (mem_beat_valid),
        .i_mem_beat       (mem_beat)
    );

    tb_mem_model #(.SALT(SALT)) u_mem (
        .clk          (clk),
        .i_mem_req    (o_mem_req),
        .i_mem_addr   (o_mem_addr),
        .o_beat_valid (mem_beat_valid),
        .o_beat       (mem_beat)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Count request rises and valid pulses on the falling edge.
    always @(negedge clk) begin
        if (o_mem_req && !req_seen) begin
            req_count++;
            req_addr = o_mem_addr;
        end
        req_seen = o_mem_req;
        if (o_instr_valid) begin
            valid_count++;
        end
    end

    // --------------------
    // Protocol assertions.
    // --------------------
    a_valid_pulse: assert property (@(posedge clk) disable iff (arst)
        o_instr_valid |=> !o_instr_valid)
        else begin
            errors++;
            $display("Error at %0d ns: o_instr_valid stayed high for two cycles", $time);
        end

    a_valid_idle: assert property (@(posedge clk) disable iff (arst)
        o_instr_valid |-> !o_busy)
        else begin
            errors++;
            $display("Error at %0d ns: o_busy still high with o_instr_valid", $time);
        end

    a_req_busy: assert property (@(posedge clk) disable iff (arst)
        o_mem_req |-> o_busy)
        else begin
            errors++;
            $display("Error at %0d ns: o_mem_req high while not busy", $time);
        end

    a_addr_stable: assert property (@(posedge clk) disable iff (arst)
        o_mem_req && $past(o_mem_req) |-> $stable(o_mem_addr))
        else begin
            errors++;
            $display("Error at %0d ns: o_mem_addr moved during a request", $time);
        end

    // --------------------
    // Helpers.
    // --------------------
    // An aligned word holds its own low address bits XORed with the salt.
    function automatic instr_t expected_word(input addr_t addr);
        return addr[31:0] ^ SALT;
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("Error at %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (o_busy && n < LIMIT && !aborted) begin
            @(negedge clk);
            n++;
        end
        if (o_busy && !aborted) begin
            $display("Timeout: o_busy stayed high for %0d cycles", LIMIT);
            aborted = 1'b1;
        end
    endtask

    // Nonzero pulse_at raises i_fetch_req again that many cycles after acceptance.
    task automatic fetch(input addr_t addr, input int pulse_at, output int edges);
        edges = 0;
        wait_idle();
        if (aborted) return;
        i_fetch_req  = 1'b1;
        i_fetch_addr = addr;
        @(negedge clk);
        i_fetch_req = 1'b0;
        check_value("o_busy", 1, o_busy);
        while (!o_instr_valid && edges < LIMIT) begin
            @(negedge clk);
            edges++;
            i_fetch_req  = (edges == pulse_at);
            i_fetch_addr = addr ^ 64'h100;
        end
        i_fetch_req = 1'b0;
        if (!o_instr_valid) begin
            $display("Timeout: no o_instr_valid for address 0x%0h", addr);
            aborted = 1'b1;
        end
    endtask

    task automatic fetch_and_check(input addr_t addr, input int exp_reqs,
                                   input bit hit_timing, input int pulse_at);
        int     edges;
        int     reqs_before;
        int     valid_before;
        logic   ma;
        instr_t exp_instr;
        reqs_before  = req_count;
        valid_before = valid_count;
        ma           = |addr[1:0];
        exp_instr    = ma ? '0 : expected_word(addr);
        fetch(addr, pulse_at, edges);
        if (aborted) return;
        check_value("o_instr", exp_instr, o_instr);
        check_value("o_instr_addr_ma", ma, o_instr_addr_ma);
        check_value("o_mem_req rises", exp_reqs, req_count - reqs_before);
        if (exp_reqs > 0) begin
            check_value("o_mem_addr", {addr[63:6], 6'd0}, req_addr);
        end
        if (hit_timing) begin
            check_value("latency in edges", 2, edges);
        end
        // One more edge so the pulse counter has settled.
        @(negedge clk);
        check_value("o_instr_valid pulses", 1, valid_count - valid_before);
        check_value("o_busy", 0, o_busy);
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before && !aborted) begin
            $display("Test %s: ok", name);
        end
        else begin
            failed_tests++;
            $display("Test %s: %0d errors, timeout %0d", name, errors - errors_before, aborted);
        end
    endtask

    // --------------------
    // Stimulus.
    // --------------------
    initial begin
        int    e;
        addr_t a;
        void'($urandom(32'h0a2c_3191));
        arst         = 1'b1;
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        i_flush      = 1'b0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        req_count    = 0;
        valid_count  = 0;
        req_seen     = 1'b0;
        aborted      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst = 1'b0;

        e = errors;
        check_value("o_instr_valid", 0, o_instr_valid);
        check_value("o_busy", 0, o_busy);
        check_value("o_mem_req", 0, o_mem_req);
        base = {$urandom, $urandom} & ~64'h3f;
        fetch_and_check(base, 1, 0, 0);
        end_test("reset", e);

        e = errors;
        for (int off = 0; off < 16; off++) begin
            fetch_and_check(base + 64'(4 * off), 0, 1, 0);
        end
        end_test("hit", e);

        // Same index, other tag, then four lines side by side.
        e = errors;
        a = base ^ 64'h100 ^ 64'(4 * $urandom_range(15, 0));
        fetch_and_check(a, 1, 0, 0);
        fetch_and_check(base, 1, 0, 0);
        for (int i = 0; i < 4; i++) begin
            spread[i] = {base[63:8] ^ 56'h2, 2'(i), 4'($urandom_range(15, 0)), 2'b00};
            fetch_and_check(spread[i], 1, 0, 0);
        end
        for (int i = 0; i < 4; i++) begin
            fetch_and_check(spread[i], 0, 1, 0);
        end
        end_test("conflict", e);

        e = errors;
        for (int i = 1; i < 4; i++) begin
            fetch_and_check(spread[0] | 64'(i), 0, 1, 0);
        end
        fetch_and_check({$urandom, $urandom} | 64'h1, 0, 1, 0);
        end_test("misaligned", e);

        e = errors;
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        for (int i = 0; i < 4; i++) begin
            fetch_and_check(spread[i], 1, 0, 0);
        end
        end_test("flush", e);

        // Extra requests during a refill and during a hit.
        e = errors;
        fetch_and_check(base ^ 64'h300, 1, 0, 2);
        fetch_and_check((base ^ 64'h300) | 64'h3c, 0, 1, 1);
        end_test("busy", e);

        $display("Tests: %0d run, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0 && !aborted) begin
            $display("TESTS PASSED");
        end
        else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== instr_fetch_top.f ====
rtl/cache_pkg.sv
rtl/fetch_pkg.sv
rtl/cache_lookup_if.sv
rtl/instr_cache.sv
rtl/line_assembler.sv
rtl/fetch_ctrl.sv
rtl/fetch_result.sv
rtl/instr_fetch_top.sv
sim/tb_mem_model.sv
sim/tb_instr_fetch_top.sv

// ==== Bender.yml ====
package:
  name: instr_fetch

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/fetch_pkg.sv
      - rtl/cache_lookup_if.sv
      - rtl/instr_cache.sv
      - rtl/line_assembler.sv
      - rtl/fetch_ctrl.sv
      - rtl/fetch_result.sv
      - rtl/instr_fetch_top.sv
  - target: simulation
    files:
      - sim/tb_mem_model.sv
      - sim/tb_instr_fetch_top.sv
